// File: Makefile
VERILATOR = verilator
TOP       = tb_dma_top
FILELIST  = list.f
FLAGS     = --timing --assert
BUILD_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/dma_bus_master.sv
// DMA memory bus grant controller
module dma_bus_master #(
   parameter int NUM_CHAN = 3
) (
   input  logic                              sys_clk,
   input  logic                              rst,
   input  logic                              mem_grant_i,
   input  logic [NUM_CHAN-1:0]               winner_i,
   input  logic                              valid_i,
   input  dma_pkg::mem_req_t [NUM_CHAN-1:0] chan_mem_i,
   input  logic [NUM_CHAN-1:0]               done_i,
   output logic [NUM_CHAN-1:0]               start_o,
   output dma_pkg::mem_req_t                 mem_o,
   output logic                              grant_done_o
);

   typedef enum logic [1:0] {IDLE, ASSIGN, WAIT} state_t;

   state_t              state_q, state_d;
   logic [NUM_CHAN-1:0] owner_q;           // one-hot bus holder, zero when free

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         state_q <= IDLE;
         owner_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == ASSIGN) begin
            owner_q <= winner_i;
         end else if (grant_done_o) begin
            owner_q <= '0;
         end
      end
   end

   always_comb begin
      state_d      = state_q;
      start_o      = '0;
      grant_done_o = 1'b0;
      case (state_q)
         IDLE: begin
            if (mem_grant_i) begin
               state_d = ASSIGN;
            end
         end
         ASSIGN: begin
            start_o = winner_i;            // all zero when nobody is eligible
            state_d = valid_i ? WAIT : IDLE;
         end
         WAIT: begin
            if (|done_i) begin
               grant_done_o = 1'b1;
               state_d      = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   // forward the holder's request
   always_comb begin
      mem_o = '0;
      for (int i = 0; i < NUM_CHAN; i++) begin
         if (owner_q[i]) begin
            mem_o = chan_mem_i[i];
         end
      end
   end

endmodule

// File: hw/dma_channel.sv
// DMA channel engine
module dma_channel (
   input  logic                       sys_clk,
   input  logic                       rst,
   input  dma_pkg::chan_cfg_t         cfg_i,
   input  logic                       start_i,
   input  logic                       mem_ack_i,
   input  logic [dma_pkg::DATA_W-1:0] mem_rdata_i,
   input  dma_pkg::dev_in_t           dev_i,
   output logic                       req_o,
   output logic                       start_clr_o,
   output dma_pkg::mem_req_t          mem_o,
   output dma_pkg::dev_out_t          dev_o,
   output logic                       done_o,
   output logic                       block_end_o
);
   import dma_pkg::*;

   typedef enum logic [3:0] {
      IDLE,
      START,
      READ_ACK,
      STEP,
      CHANNEL_WR,
      CHANNEL_RE,
      WRITE_PREP,
      WRITE_ACK,
      WRITE_DONE
   } state_t;

   state_t            state_q, state_d;
   logic              req_q, req_d;
   logic              ren_q, ren_d;
   logic              wen_q, wen_d;
   logic              to_dev_q;
   logic [ADDR_W-1:0] addr_q;
   logic [CNT_W-1:0]  cnt_q;
   logic [DATA_W-1:0] data_q;              // word in flight, either direction
   logic              claim;
   logic              step;
   logic              latch_mem;
   logic              latch_dev;

   assign req_o = req_q;
   assign mem_o = '{ren: ren_q, wen: wen_q, addr: addr_q, wdata: data_q};

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         state_q <= IDLE;
         req_q   <= 1'b0;
         ren_q   <= 1'b0;
         wen_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         req_q   <= req_d;
         ren_q   <= ren_d;
         wen_q   <= wen_d;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (claim) begin
         addr_q   <= cfg_i.madr;
         cnt_q    <= cfg_i.words;
         to_dev_q <= cfg_i.to_device;
      end else if (step) begin
         addr_q <= addr_q + ADDR_W'(WORD_STEP); // always counts upward
         cnt_q  <= cnt_q - CNT_W'(1);
      end
      if (latch_mem) begin
         data_q <= mem_rdata_i;
      end else if (latch_dev) begin
         data_q <= dev_i.rdata;
      end
   end

   always_comb begin
      state_d     = state_q;
      req_d       = req_q;
      ren_d       = ren_q;
      wen_d       = wen_q;
      claim       = 1'b0;
      step        = 1'b0;
      latch_mem   = 1'b0;
      latch_dev   = 1'b0;
      start_clr_o = 1'b0;
      done_o      = 1'b0;
      block_end_o = 1'b0;
      dev_o       = '0;
      dev_o.wdata = data_q;
      case (state_q)
         IDLE: begin
            if (!req_q) begin
               if (cfg_i.start) begin
                  start_clr_o = 1'b1;      // register file drops the start bit
                  claim       = 1'b1;
                  req_d       = 1'b1;
               end
            end else if (start_i) begin
               state_d = START;
            end
         end
         START: begin
            if (cnt_q == '0) begin
               done_o      = 1'b1;         // block finished, release the bus
               block_end_o = 1'b1;
               req_d       = 1'b0;
               state_d     = IDLE;
            end else if (to_dev_q) begin
               ren_d   = 1'b1;
               state_d = READ_ACK;
            end else begin
               state_d = CHANNEL_RE;
            end
         end
         READ_ACK: begin
            if (mem_ack_i) begin
               ren_d     = 1'b0;
               latch_mem = 1'b1;           // data valid only while ack is high
               state_d   = STEP;
            end
         end
         STEP: begin
            step    = 1'b1;
            state_d = CHANNEL_WR;
         end
         CHANNEL_WR: begin
            if (!dev_i.full) begin
               dev_o.wen = 1'b1;
               done_o    = 1'b1;
               state_d   = IDLE;
            end
         end
         CHANNEL_RE: begin
            if (dev_i.rdy) begin
               dev_o.ren = 1'b1;
               latch_dev = 1'b1;
               state_d   = WRITE_PREP;
            end
         end
         WRITE_PREP: begin
            wen_d   = 1'b1;
            state_d = WRITE_ACK;
         end
         WRITE_ACK: begin
            if (mem_ack_i) begin
               wen_d   = 1'b0;
               step    = 1'b1;
               state_d = WRITE_DONE;
            end
         end
         WRITE_DONE: begin
            if (!mem_ack_i) begin          // memory has let go of the bus
               done_o  = 1'b1;
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

endmodule

// File: hw/dma_irq_reg.sv
// DMA interrupt control register
module dma_irq_reg #(
   parameter int NUM_CHAN = 3
) (
   input  logic                sys_clk,
   input  logic                rst,
   input  logic [NUM_CHAN-1:0] block_end_i,
   input  logic                wen_i,
   input  logic [31:0]         wdata_i,
   output logic [31:0]         dicr_o
);
   import dma_pkg::*;

   logic [31:0]         dicr_q, dicr_d;
   logic [MAX_CHAN-1:0] blk_end;           // padded to the full register width
   logic [MAX_CHAN-1:0] irq_en;
   logic [MAX_CHAN-1:0] flags;

   assign blk_end = MAX_CHAN'(block_end_i);
   assign irq_en  = dicr_q[DICR_EN_LSB +: MAX_CHAN];
   assign flags   = dicr_q[DICR_FLAG_LSB +: MAX_CHAN];
   assign dicr_o  = dicr_q;

   always_ff @(posedge sys_clk, posedge rst) begin
      if (rst) begin
         dicr_q <= '0;
      end else begin
         dicr_q <= dicr_d;
      end
   end

   always_comb begin
      dicr_d = dicr_q;
      // master flag lags force and enabled flags by one cycle
      dicr_d[DICR_MASTER_BIT] = dicr_q[DICR_FORCE_BIT] | (|(irq_en & flags));
      if (wen_i) begin
         dicr_d[5:0]                          = wdata_i[5:0];
         dicr_d[DICR_FORCE_BIT-1:6]           = '0;
         dicr_d[DICR_MEN_BIT:DICR_FORCE_BIT]  = wdata_i[DICR_MEN_BIT:DICR_FORCE_BIT];
         dicr_d[DICR_FLAG_LSB +: MAX_CHAN]    = flags & ~wdata_i[DICR_FLAG_LSB +: MAX_CHAN];
      end else if (dicr_q[DICR_MEN_BIT]) begin
         dicr_d[DICR_FLAG_LSB +: MAX_CHAN] = flags | (irq_en & blk_end); // set only
      end
   end

endmodule

// File: hw/dma_pkg.sv
// DMA controller shared definitions
package dma_pkg;

   localparam int ADDR_W    = 32;          // memory address width
   localparam int DATA_W    = 32;          // memory and device word width
   localparam int CNT_W     = 16;          // block word count width
   localparam int PRIO_W    = 3;           // per-channel priority field
   localparam int MAX_CHAN  = 7;           // channels the control words can describe
   localparam int WORD_STEP = 4;           // byte step per word

   // DPCR layout, one nibble per channel with enable on top
   localparam int DPCR_FIELD_W = 4;

   // DICR layout
   localparam int DICR_FORCE_BIT  = 15;
   localparam int DICR_EN_LSB     = 16;    // per-channel enables
   localparam int DICR_MEN_BIT    = 23;    // master enable
   localparam int DICR_FLAG_LSB   = 24;    // per-channel flags
   localparam int DICR_MASTER_BIT = 31;

   // channel registers as the CPU register file presents them
   typedef struct packed {
      logic [ADDR_W-1:0] madr;             // start address
      logic [CNT_W-1:0]  words;            // block length in words
      logic              to_device;        // 1 means memory to peripheral
      logic              start;
   } chan_cfg_t;

   // one master's request on the memory bus
   typedef struct packed {
      logic              ren;
      logic              wen;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              rdy;              // source word available
      logic              full;             // sink FIFO full
      logic [DATA_W-1:0] rdata;
   } dev_in_t;

   typedef struct packed {
      logic              ren;              // pop, one cycle
      logic              wen;              // push, one cycle
      logic [DATA_W-1:0] wdata;
   } dev_out_t;

endpackage

// File: hw/dma_priority_arbiter.sv
// DMA channel priority arbiter
module dma_priority_arbiter #(
   parameter int NUM_CHAN = 3
) (
   input  logic [31:0]         dpcr_i,
   input  logic [NUM_CHAN-1:0] req_i,
   output logic [NUM_CHAN-1:0] winner_o,
   output logic                valid_o
);
   import dma_pkg::*;

   logic [NUM_CHAN-1:0] elig;              // enabled and requesting
   logic [PRIO_W-1:0]   prio [NUM_CHAN];

   always_comb begin
      for (int i = 0; i < NUM_CHAN; i++) begin
         prio[i] = dpcr_i[i*DPCR_FIELD_W +: PRIO_W];
         elig[i] = req_i[i] & dpcr_i[i*DPCR_FIELD_W + DPCR_FIELD_W - 1];
      end
   end

   // lower value wins, lower index breaks a tie
   always_comb begin
      for (int i = 0; i < NUM_CHAN; i++) begin
         winner_o[i] = elig[i];
         for (int j = 0; j < NUM_CHAN; j++) begin
            if (j < i && elig[j] && prio[j] <= prio[i]) begin
               winner_o[i] = 1'b0;
            end else if (j > i && elig[j] && prio[j] < prio[i]) begin
               winner_o[i] = 1'b0;
            end
         end
      end
   end

   assign valid_o = |winner_o;

endmodule

// File: hw/dma_top.sv
// DMA controller top level
module dma_top #(
   parameter int NUM_CHAN = 3
) (
   input  logic                              sys_clk,
   input  logic                              rst,
   input  dma_pkg::chan_cfg_t [NUM_CHAN-1:0] cfg_i,
   input  logic [31:0]                       dpcr_i,
   input  logic                              mem_grant_i,
   input  logic                              mem_ack_i,
   input  logic [dma_pkg::DATA_W-1:0]        mem_rdata_i,
   input  dma_pkg::dev_in_t [NUM_CHAN-1:0]   dev_i,
   input  logic                              dicr_wen_i,
   input  logic [31:0]                       dicr_wdata_i,
   output logic [NUM_CHAN-1:0]               start_clr_o,
   output dma_pkg::dev_out_t [NUM_CHAN-1:0]  dev_o,
   output dma_pkg::mem_req_t                 mem_o,
   output logic                              grant_done_o,
   output logic                              dma_req_o,
   output logic [31:0]                       dicr_o
);
   import dma_pkg::*;

   logic [NUM_CHAN-1:0]     chan_req;
   logic [NUM_CHAN-1:0]     chan_done;
   logic [NUM_CHAN-1:0]     chan_start;
   logic [NUM_CHAN-1:0]     block_end;
   logic [NUM_CHAN-1:0]     winner;
   logic                    winner_valid;
   mem_req_t [NUM_CHAN-1:0] chan_mem;

   assign dma_req_o = |chan_req;           // asks the memory controller for the bus

   for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
      dma_channel chan_i (
         .sys_clk     (sys_clk),
         .rst         (rst),
         .cfg_i       (cfg_i[i]),
         .start_i     (chan_start[i]),
         .mem_ack_i   (mem_ack_i),
         .mem_rdata_i (mem_rdata_i),
         .dev_i       (dev_i[i]),
         .req_o       (chan_req[i]),
         .start_clr_o (start_clr_o[i]),
         .mem_o       (chan_mem[i]),
         .dev_o       (dev_o[i]),
         .done_o      (chan_done[i]),
         .block_end_o (block_end[i])
      );
   end

   dma_priority_arbiter #(.NUM_CHAN(NUM_CHAN)) arb_i (
      .dpcr_i   (dpcr_i),
      .req_i    (chan_req),
      .winner_o (winner),
      .valid_o  (winner_valid)
   );

   dma_bus_master #(.NUM_CHAN(NUM_CHAN)) bus_i (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .mem_grant_i  (mem_grant_i),
      .winner_i     (winner),
      .valid_i      (winner_valid),
      .chan_mem_i   (chan_mem),
      .done_i       (chan_done),
      .start_o      (chan_start),
      .mem_o        (mem_o),
      .grant_done_o (grant_done_o)
   );

   dma_irq_reg #(.NUM_CHAN(NUM_CHAN)) irq_i (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .block_end_i (block_end),
      .wen_i       (dicr_wen_i),
      .wdata_i     (dicr_wdata_i),
      .dicr_o      (dicr_o)
   );

endmodule

// File: list.f
hw/dma_pkg.sv
hw/dma_channel.sv
hw/dma_priority_arbiter.sv
hw/dma_bus_master.sv
hw/dma_irq_reg.sv
hw/dma_top.sv
verification/dma_props.sv
verification/tb_dma_top.sv

// File: verification/dma_input.txt
// first word: record count; per record a line "dpcr dicr", then one line per channel
// channel columns: to_device madr words seed0 seed1 seed2 seed3
3
00000B9A 00870000
1 00001000 0003 A0000001 A0000002 A0000003 00000000
0 00002000 0004 B0000001 B0000002 B0000003 B0000004
1 00003000 0002 C0000001 C0000002 00000000 00000000
00000A2A 00058015
0 00004000 0002 D0000001 D0000002 00000000 00000000
1 00005000 0003 E0000001 E0000002 E0000003 00000000
0 00006000 0004 F0000001 F0000002 F0000003 F0000004
000009CB 00820003
1 00007000 0001 12340001 00000000 00000000 00000000
1 00008000 0004 56780001 56780002 56780003 56780004
0 00009000 0003 9ABC0001 9ABC0002 9ABC0003 00000000

// File: verification/dma_props.sv
// DMA bus master assertions
module dma_props #(
   parameter int NUM_CHAN = 3
) (
   input logic                sys_clk,
   input logic                rst,
   input logic                mem_grant_i,
   input logic [NUM_CHAN-1:0] start_o,
   input dma_pkg::mem_req_t   mem_o
);
   timeunit 1ns;
   timeprecision 100ps;

   a_start_onehot: assert property (@(posedge sys_clk) disable iff (rst)
      $onehot0(start_o)) else $error("more than one channel started at once");

   a_start_after_grant: assert property (@(posedge sys_clk) disable iff (rst)
      |start_o |-> $past(mem_grant_i)) else $error("start without a preceding grant");

   a_no_rw_overlap: assert property (@(posedge sys_clk) disable iff (rst)
      !(mem_o.ren && mem_o.wen)) else $error("read and write requested together");

endmodule

bind dma_bus_master dma_props #(.NUM_CHAN(NUM_CHAN)) props_i (
   .sys_clk     (sys_clk),
   .rst         (rst),
   .mem_grant_i (mem_grant_i),
   .start_o     (start_o),
   .mem_o       (mem_o)
);

// File: verification/tb_dma_top.sv
// DMA controller testbench
module tb_dma_top;
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   localparam int NUM_CHAN = 3;
   localparam int NUM_SEED = 4;
   localparam int NUM_REC  = 3;
   localparam int REC_LEN  = 2 + NUM_CHAN * (3 + NUM_SEED);
   localparam int STIM_LEN = 1 + NUM_REC * REC_LEN;

   logic                      sys_clk = 1'b0;
   logic                      rst;
   chan_cfg_t [NUM_CHAN-1:0]  cfg;
   logic [31:0]               dpcr;
   logic                      mem_grant_i, mem_ack_i;
   logic [DATA_W-1:0]         mem_rdata_i;
   dev_in_t [NUM_CHAN-1:0]    dev_in;
   logic                      dicr_wen;
   logic [31:0]               dicr_wdata;
   logic [NUM_CHAN-1:0]       start_clr;
   dev_out_t [NUM_CHAN-1:0]   dev_out;
   mem_req_t                  mem_req;
   logic                      grant_done, dma_req;
   logic [31:0]               dicr;

   logic [31:0] stim [STIM_LEN];
   logic [31:0] mem_model [logic [31:0]];
   logic [31:0] src_q [NUM_CHAN][$];
   logic [31:0] sink_q [NUM_CHAN][$];
   logic [31:0] madr_r [NUM_CHAN];
   logic [31:0] seed_r [NUM_CHAN][NUM_SEED];
   bit          dir_r [NUM_CHAN];        // 1 means memory to device
   int          words_r [NUM_CHAN];
   int          acc_cnt [NUM_CHAN];
   int          first_ch, wr_cnt, ack_wait;
   int          limit_cycles = 0;

   dma_top #(.NUM_CHAN(NUM_CHAN)) dut_i (
      .sys_clk (sys_clk), .rst (rst), .cfg_i (cfg), .dpcr_i (dpcr),
      .mem_grant_i (mem_grant_i), .mem_ack_i (mem_ack_i), .mem_rdata_i (mem_rdata_i),
      .dev_i (dev_in), .dicr_wen_i (dicr_wen), .dicr_wdata_i (dicr_wdata),
      .start_clr_o (start_clr), .dev_o (dev_out), .mem_o (mem_req),
      .grant_done_o (grant_done), .dma_req_o (dma_req), .dicr_o (dicr)
   );

   always #10 sys_clk = ~sys_clk;

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("FAILED at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
         $display("Checks failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // which channel's block of the current record covers this address
   function automatic int chan_of_addr(input logic [31:0] a);
      for (int c = 0; c < NUM_CHAN; c++) begin
         if (a >= madr_r[c] && a < madr_r[c] + 32'(4 * words_r[c])) return c;
      end
      return -1;
   endfunction

   function automatic logic [31:0] mem_read(input logic [31:0] a);
      return mem_model.exists(a) ? mem_model[a] : ~{a[15:0], a[31:16]}; // fill pattern
   endfunction

   function automatic int expected_first(input logic [31:0] ctrl);
      int best;
      best = -1;
      for (int c = 0; c < NUM_CHAN; c++) begin
         if (ctrl[4*c+3] && words_r[c] > 0) begin
            if (best < 0 || ctrl[4*c +: 3] < ctrl[4*best +: 3]) best = c;
         end
      end
      return best;
   endfunction

   function automatic bit enabled_done(input logic [31:0] ctrl);
      for (int c = 0; c < NUM_CHAN; c++) begin
         if (ctrl[4*c+3]) begin
            if (dir_r[c] && sink_q[c].size() != words_r[c]) return 1'b0;
            if (!dir_r[c] && acc_cnt[c] != words_r[c]) return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // memory, devices, register file and memory controller models
   always @(posedge sys_clk) begin
      mem_req_t            req_s;
      dev_out_t [NUM_CHAN-1:0] dout_s;
      logic [NUM_CHAN-1:0] clr_s;
      logic                gd_s, dreq_s;
      int                  ch;
      bit                  wr_ok;
      if (!rst) begin
         req_s  = mem_req;
         dout_s = dev_out;
         clr_s  = start_clr;
         gd_s   = grant_done;
         dreq_s = dma_req;
         #2;
         if (req_s.ren || req_s.wen) begin
            if (!mem_ack_i) begin
               if (ack_wait != 0) begin
                  ack_wait--;
               end else begin
                  mem_ack_i = 1'b1;
                  ch = chan_of_addr(req_s.addr);
                  if (first_ch < 0) first_ch = ch;
                  if (ch >= 0) acc_cnt[ch]++;
                  if (req_s.wen) begin
                     wr_ok = (ch >= 0) ? !dir_r[ch] : 1'b0;
                     check_eq(32'(wr_ok), 32'd1, "memory write outside a device-to-memory block");
                     mem_model[req_s.addr] = req_s.wdata;
                     wr_cnt++;
                  end else begin
                     mem_rdata_i = mem_read(req_s.addr);
                  end
               end
            end
         end else begin
            mem_ack_i = 1'b0;
            ack_wait  = int'($urandom_range(3));
         end
         for (int c = 0; c < NUM_CHAN; c++) begin
            if (dout_s[c].ren) void'(src_q[c].pop_front());
            if (dout_s[c].wen) sink_q[c].push_back(dout_s[c].wdata);
            if (clr_s[c]) cfg[c].start = 1'b0;
            dev_in[c].rdy   = src_q[c].size() > 0 && $urandom_range(3) != 0;
            dev_in[c].rdata = (src_q[c].size() > 0) ? src_q[c][0] : '0;
            dev_in[c].full  = $urandom_range(3) == 0;
         end
         mem_grant_i = gd_s ? 1'b0 : dreq_s;   // one idle cycle after each grant
      end
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge sys_clk);
      $display("watchdog expired, the DMA transfers never completed");
      $display("Checks failed");
      $fatal(1, "timeout");
   end

   initial begin
      int          base, total, exp_first;
      logic [31:0] ctrl, irq_w, exp_bit;
      bit          men;
      bit          any_flag;
      rst = 1'b1;
      cfg = '0;
      dpcr = '0;
      mem_grant_i = 1'b0;
      mem_ack_i = 1'b0;
      mem_rdata_i = '0;
      dev_in = '0;
      dicr_wen = 1'b0;
      dicr_wdata = '0;
      ack_wait = 0;
      void'($urandom(32'hf444_275e));
      $readmemh("verification/dma_input.txt", stim);
      total = 0;
      for (int r = 0; r < int'(stim[0]); r++) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            total += int'(stim[1 + r*REC_LEN + 2 + c*(3+NUM_SEED) + 2][15:0]);
         end
      end
      limit_cycles = 200 * total + 1000;
      repeat (3) @(posedge sys_clk);
      #2 rst = 1'b0;
      @(negedge sys_clk);
      check_eq(32'({mem_req.ren, mem_req.wen}), 32'd0, "memory strobes after reset");
      check_eq(32'(start_clr), 32'd0, "start_clr after reset");
      check_eq(32'(grant_done), 32'd0, "grant_done after reset");
      check_eq(32'(dma_req), 32'd0, "bus request after reset");
      for (int c = 0; c < NUM_CHAN; c++) begin
         check_eq(32'({dev_out[c].ren, dev_out[c].wen}), 32'd0, "device strobes after reset");
      end
      check_eq(dicr, 32'd0, "interrupt register after reset");

      for (int r = 0; r < int'(stim[0]); r++) begin
         base  = 1 + r * REC_LEN;
         ctrl  = stim[base];
         irq_w = stim[base + 1];
         mem_model.delete();
         first_ch = -1;
         wr_cnt   = 0;
         for (int c = 0; c < NUM_CHAN; c++) begin
            dir_r[c]   = stim[base + 2 + c*(3+NUM_SEED)][0];
            madr_r[c]  = stim[base + 3 + c*(3+NUM_SEED)];
            words_r[c] = int'(stim[base + 4 + c*(3+NUM_SEED)][15:0]);
            acc_cnt[c] = 0;
            src_q[c].delete();
            sink_q[c].delete();
            for (int k = 0; k < NUM_SEED; k++) begin
               seed_r[c][k] = stim[base + 5 + c*(3+NUM_SEED) + k];
               if (k < words_r[c] && dir_r[c]) mem_model[madr_r[c] + 32'(4*k)] = seed_r[c][k];
               if (k < words_r[c] && !dir_r[c]) src_q[c].push_back(seed_r[c][k]);
            end
         end
         @(posedge sys_clk);
         #2;
         dicr_wen   = 1'b1;
         dicr_wdata = irq_w | 32'h7f00_7fc0;  // clears old flags and probes bits 14:6
         dpcr       = ctrl;
         for (int c = 0; c < NUM_CHAN; c++) begin
            cfg[c].madr      = madr_r[c];
            cfg[c].words     = CNT_W'(words_r[c]);
            cfg[c].to_device = dir_r[c];
         end
         @(posedge sys_clk);
         #2;
         dicr_wen = 1'b0;
         for (int c = 0; c < NUM_CHAN; c++) cfg[c].start = 1'b1;
         while (!enabled_done(ctrl)) @(negedge sys_clk);
         exp_first = expected_first(ctrl);
         check_eq(32'(first_ch), 32'(exp_first), "first memory access went to the wrong channel");
         for (int c = 0; c < NUM_CHAN; c++) begin
            if (!ctrl[4*c+3]) check_eq(32'(acc_cnt[c]), 32'd0, "disabled channel used the bus");
         end
         @(posedge sys_clk);
         #2 dpcr = ctrl | 32'h0000_0888;       // let the held-back channels run
         @(negedge sys_clk);
         while (dma_req) @(negedge sys_clk);
         repeat (3) @(negedge sys_clk);

         total = 0;
         for (int c = 0; c < NUM_CHAN; c++) begin
            if (dir_r[c]) begin
               check_eq(32'(sink_q[c].size()), 32'(words_r[c]), "device sink word count");
               for (int k = 0; k < words_r[c] && k < sink_q[c].size(); k++) begin
                  check_eq(sink_q[c][k], seed_r[c][k], "device sink data");
               end
            end else begin
               total += words_r[c];
               for (int k = 0; k < words_r[c]; k++) begin
                  check_eq(mem_read(madr_r[c] + 32'(4*k)), seed_r[c][k], "memory data");
               end
            end
         end
         check_eq(32'(wr_cnt), 32'(total), "number of memory writes");

         men = irq_w[DICR_MEN_BIT];
         any_flag = 1'b0;
         for (int c = 0; c < NUM_CHAN; c++) begin
            exp_bit = 32'(men && irq_w[DICR_EN_LSB + c]);
            if (exp_bit != 0) any_flag = 1'b1;
            check_eq(32'(dicr[DICR_FLAG_LSB + c]), exp_bit, "interrupt flag");
         end
         check_eq(32'(dicr[DICR_MASTER_BIT]), 32'(irq_w[DICR_FORCE_BIT] | any_flag),
                  "interrupt master bit");
         check_eq(32'(dicr[23:0]), {8'd0, irq_w[23:15], 9'd0, irq_w[5:0]},
                  "interrupt control bits");
         @(posedge sys_clk);
         #2;
         dicr_wen   = 1'b1;
         dicr_wdata = (irq_w & 32'h00ff_ffff) | 32'h7f00_0000;
         @(posedge sys_clk);
         #2 dicr_wen = 1'b0;
         repeat (2) @(negedge sys_clk);
         check_eq(32'(dicr[30:24]), 32'd0, "flags after write-one-to-clear");
         check_eq(32'(dicr[DICR_MASTER_BIT]), 32'(irq_w[DICR_FORCE_BIT]), "master bit after clear");
      end
      $display("All checks passed");
      $finish;
   end

endmodule
